// File: eth_core.f
logic/eth_mii_pkg.sv
logic/eth_host_pkg.sv
logic/eth_crc32.sv
logic/eth_buffer_ram.sv
logic/eth_host_regs.sv
logic/eth_tx.sv
logic/eth_rx.sv
logic/eth_core.sv
testbench/eth_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator and run, a $fatal in the testbench gives a failing exit status
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module eth_core_tb -f eth_core.f -o eth_core_sim &&
./obj_dir/eth_core_sim ||
{ echo "Simulation build or run failed"; exit 1; }

// File: testbench/eth_core_tb.sv
`timescale 1ns/1ns

module eth_core_tb;

   localparam int          NUM_TESTS = 7;
   localparam int          MAX_LEN   = 48;
   localparam int          NO_ERROR  = -1;  // Clean loopback
   localparam int          LEN_W     = eth_mii_pkg::LEN_W;
   localparam logic [31:0] RESIDUE   = 32'hDEBB_20E3;

   localparam logic [8:0] CTRL_ADDR   = 9'(eth_host_pkg::CTRL);
   localparam logic [8:0] TX_LEN_ADDR = 9'(eth_host_pkg::TX_LEN);
   localparam logic [8:0] SEND_ADDR   = 9'(eth_host_pkg::SEND);
   localparam logic [8:0] STATUS_ADDR = 9'(eth_host_pkg::STATUS);
   localparam logic [8:0] RX_LEN_ADDR = 9'(eth_host_pkg::STATUS) + 9'd1;
   localparam logic [8:0] RX_ACK_ADDR = 9'(eth_host_pkg::RX_ACK);

   typedef struct packed {
      logic [7:0] len;
      logic       crc_en;
      logic       rx_en;
      logic       loopback;
      logic       ack;      // RX_ACK after the checks
      int         corrupt;  // Nibble index counted after the SFD
   } test_entry_t;

   logic                     clk_i = 1'b0;
   logic                     reset_i;
   eth_host_pkg::host_req_t  host_i;
   eth_host_pkg::host_rsp_t  host_o;
   eth_mii_pkg::mii_nibble_t mii_rx_i;
   eth_mii_pkg::mii_nibble_t mii_tx_o;
   logic                     irq_o;

   eth_host_pkg::rx_status_t exp_status;  // Receive status model
   logic [7:0]               tx_bytes [$];
   logic [7:0]               rx_bytes [$];
   eth_mii_pkg::mii_nibble_t captured [$];

   test_entry_t tests [NUM_TESTS] = '{
      '{8'd8,  1'b1, 1'b1, 1'b1, 1'b1, NO_ERROR},  // Good frame, then ack
      '{8'd20, 1'b1, 1'b1, 1'b1, 1'b0, 5},         // Data nibble flipped, left pending
      '{8'd12, 1'b1, 1'b1, 1'b1, 1'b1, NO_ERROR},  // Dropped while done is pending
      '{8'd16, 1'b0, 1'b0, 1'b1, 1'b0, NO_ERROR},  // Dropped with rx_en clear
      '{8'd1,  1'b0, 1'b1, 1'b1, 1'b1, NO_ERROR},  // No FCS
      '{8'd48, 1'b1, 1'b1, 1'b1, 1'b1, 99},        // FCS nibble flipped
      '{8'd5,  1'b1, 1'b1, 1'b0, 1'b0, NO_ERROR}   // Transmit only
   };

   eth_core uut (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .host_i  (host_i),
      .host_o  (host_o),
      .mii_rx_i(mii_rx_i),
      .mii_tx_o(mii_tx_o),
      .irq_o   (irq_o)
   );

   always #2 clk_i = ~clk_i;

   // Reflected CRC-32, one byte LSB first
   function automatic logic [31:0] crc_update(input logic [31:0] crc, input logic [7:0] data);
      logic [31:0] c;
      c = crc;
      for (int i = 0; i < 8; i++) begin
         if (c[0] ^ data[i]) begin
            c = (c >> 1) ^ 32'hEDB8_8320;
         end else begin
            c = c >> 1;
         end
      end
      return c;
   endfunction

   function automatic eth_host_pkg::host_rsp_t make_rsp(input logic [7:0] data);
      eth_host_pkg::host_rsp_t rsp;
      rsp.rvalid = 1'b1;
      rsp.rdata  = data;
      return rsp;
   endfunction

   task automatic abort_run(input string line);
      $display("%s", line);
      $display("** FAIL **");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic value_error(input string msg);
      abort_run($sformatf("FAILED at %0t ns: %s", $time, msg));
   endtask

   task automatic check_nibble(input eth_mii_pkg::mii_nibble_t got,
                               input eth_mii_pkg::mii_nibble_t exp, input int idx);
      if (got !== exp) begin
         value_error($sformatf("MII nibble %0d is en=%b data=%h, expected en=%b data=%h",
                               idx, got.en, got.data, exp.en, exp.data));
      end
   endtask

   task automatic check_rsp(input eth_host_pkg::host_rsp_t got,
                            input eth_host_pkg::host_rsp_t exp, input string what);
      if (got !== exp) begin
         value_error($sformatf("%s reads rvalid=%b data=%h, expected rvalid=%b data=%h",
                               what, got.rvalid, got.rdata, exp.rvalid, exp.rdata));
      end
   endtask

   task automatic check_status(input eth_host_pkg::rx_status_t got,
                               input eth_host_pkg::rx_status_t exp);
      if (got !== exp) begin
         value_error($sformatf("Rx status done=%b crc_err=%b len=%0d, expected %b %b %0d",
                               got.done, got.crc_err, got.len,
                               exp.done, exp.crc_err, exp.len));
      end
   endtask

   // Both host tasks start and end 1 ns after a rising edge
   task automatic write_host(input logic [8:0] addr, input logic [7:0] data);
      host_i.wr    = 1'b1;
      host_i.addr  = addr;
      host_i.wdata = data;
      @(posedge clk_i);
      #1;
      host_i.wr = 1'b0;
   endtask

   task automatic read_host(input logic [8:0] addr, output eth_host_pkg::host_rsp_t rsp);
      host_i.rd   = 1'b1;
      host_i.addr = addr;
      @(negedge clk_i);
      if (host_o.rvalid !== 1'b0) abort_run("rvalid came before the read strobe was taken");
      @(posedge clk_i);
      #1;
      host_i.rd = 1'b0;
      @(negedge clk_i);
      rsp = host_o;
      if (rsp.rvalid !== 1'b1) abort_run("rvalid missing one cycle after the read strobe");
      @(posedge clk_i);
      #1;
      if (host_o.rvalid !== 1'b0) abort_run("rvalid stayed high for more than one cycle");
   endtask

   task automatic read_status(output eth_host_pkg::rx_status_t st, output logic busy);
      eth_host_pkg::host_rsp_t rsp;
      read_host(STATUS_ADDR, rsp);
      busy       = rsp.rdata[0];
      st.done    = rsp.rdata[1];
      st.crc_err = rsp.rdata[2];
      read_host(RX_LEN_ADDR, rsp);
      st.len = rsp.rdata;
   endtask

   task automatic run_entry(input test_entry_t t);
      eth_host_pkg::host_rsp_t  rsp;
      eth_host_pkg::rx_status_t st;
      eth_mii_pkg::mii_nibble_t exp_nib;
      eth_mii_pkg::mii_nibble_t nib;
      logic [31:0]              crc;
      logic [7:0]               ctrl;
      logic [7:0]               cur;
      logic                     busy;
      logic                     accept;
      int                       n_nib;
      int                       waited;

      ctrl = {5'b0, t.crc_en, t.rx_en, 1'b1};
      write_host(CTRL_ADDR, ctrl);
      read_host(CTRL_ADDR, rsp);
      check_rsp(rsp, make_rsp(ctrl), "CTRL");
      write_host(TX_LEN_ADDR, t.len);
      read_host(TX_LEN_ADDR, rsp);
      check_rsp(rsp, make_rsp(t.len), "TX_LEN");

      tx_bytes.delete();
      crc = 32'hFFFF_FFFF;
      for (int i = 0; i < int'(t.len); i++) begin
         tx_bytes.push_back(8'($urandom));
         crc = crc_update(crc, tx_bytes[i]);
         write_host({2'b10, 7'(i)}, tx_bytes[i]);
      end
      if (t.crc_en) begin
         crc = ~crc;  // FCS bytes, least significant first
         for (int k = 0; k < 4; k++) tx_bytes.push_back(crc[8*k +: 8]);
      end
      n_nib = 16 + 2 * tx_bytes.size();

      write_host(SEND_ADDR, 8'h00);
      waited = 0;
      @(negedge clk_i);
      while (mii_tx_o.en !== 1'b1) begin
         waited++;
         if (waited > 4) abort_run("Transmitter never raised tx_en after SEND");
         @(negedge clk_i);
      end
      if (waited != 1) value_error($sformatf("tx_en rose %0d cycles late", waited - 1));

      captured.delete();
      for (int k = 0; k < n_nib; k++) begin
         exp_nib.en = 1'b1;
         if (k < 15) begin
            exp_nib.data = 4'h5;
         end else if (k == 15) begin
            exp_nib.data = 4'hD;
         end else begin
            cur          = tx_bytes[(k - 16) / 2];
            exp_nib.data = ((k - 16) % 2 == 1) ? cur[7:4] : cur[3:0];
         end
         check_nibble(mii_tx_o, exp_nib, k);
         captured.push_back(mii_tx_o);
         @(negedge clk_i);
      end
      if (mii_tx_o.en !== 1'b0) value_error("tx_en still high after the last nibble");
      @(posedge clk_i);
      #1;

      accept = 1'b0;
      if (t.loopback) begin
         for (int k = 0; k < n_nib; k++) begin
            nib = captured[k];
            if (t.corrupt >= 0 && k == t.corrupt + 16) nib.data = ~nib.data;
            mii_rx_i = nib;
            @(posedge clk_i);
            #1;
         end
         mii_rx_i = '0;

         rx_bytes = tx_bytes;
         if (t.corrupt >= 0) begin
            rx_bytes[t.corrupt / 2] ^= (t.corrupt % 2 == 1) ? 8'hF0 : 8'h0F;
         end
         accept = t.rx_en && !exp_status.done;  // Otherwise dropped whole
         if (accept) begin
            crc = 32'hFFFF_FFFF;
            foreach (rx_bytes[i]) crc = crc_update(crc, rx_bytes[i]);
            exp_status.done    = 1'b1;
            exp_status.crc_err = (crc != RESIDUE);
            exp_status.len     = LEN_W'(rx_bytes.size());
            waited = 0;
            while (irq_o !== 1'b1) begin
               waited++;
               if (waited > 4) abort_run("Receiver never signalled done after the frame");
               @(posedge clk_i);
               #1;
            end
         end else begin
            repeat (4) @(posedge clk_i);
            #1;
         end
      end

      read_status(st, busy);
      if (busy !== 1'b0) value_error("tx_busy still set after the frame");
      check_status(st, exp_status);
      if (irq_o !== exp_status.done) value_error("irq_o does not follow rx done");

      if (accept) begin
         foreach (rx_bytes[i]) begin
            read_host({2'b10, 7'(i)}, rsp);
            check_rsp(rsp, make_rsp(rx_bytes[i]), $sformatf("Rx buffer byte %0d", i));
         end
      end

      if (t.ack) begin
         write_host(RX_ACK_ADDR, 8'h00);
         exp_status.done = 1'b0;  // crc_err and len stay
         waited = 0;
         while (irq_o !== 1'b0) begin
            waited++;
            if (waited > 4) abort_run("RX_ACK did not clear the done flag");
            @(posedge clk_i);
            #1;
         end
         read_status(st, busy);
         check_status(st, exp_status);
      end
   endtask

   initial begin
      repeat (16 + NUM_TESTS * (8 + 6 * MAX_LEN + 200)) @(posedge clk_i);
      abort_run("Watchdog expired, the simulation hung");
   end

   initial begin
      eth_host_pkg::host_rsp_t  rsp;
      eth_host_pkg::rx_status_t st;
      logic                     busy;

      void'($urandom(32'hd2b4));
      reset_i    = 1'b1;
      host_i     = '0;
      mii_rx_i   = '0;
      exp_status = '0;
      repeat (16) @(posedge clk_i);
      #1;
      reset_i = 1'b0;

      @(negedge clk_i);
      if (mii_tx_o.en !== 1'b0) value_error("tx_en high after reset");
      if (irq_o !== 1'b0) value_error("irq_o high after reset");
      @(posedge clk_i);
      #1;
      read_host(CTRL_ADDR, rsp);
      check_rsp(rsp, make_rsp(8'h00), "CTRL after reset");
      read_status(st, busy);
      if (busy !== 1'b0) value_error("tx_busy high after reset");
      check_status(st, exp_status);

      foreach (tests[i]) run_entry(tests[i]);

      $display("** PASS **");
      $finish;
   end

endmodule

// File: logic/eth_core.sv
`timescale 1ns/1ns

module eth_core (
   input  logic                     clk_i,
   input  logic                     reset_i,
   input  eth_host_pkg::host_req_t  host_i,
   output eth_host_pkg::host_rsp_t  host_o,
   input  eth_mii_pkg::mii_nibble_t mii_rx_i,
   output eth_mii_pkg::mii_nibble_t mii_tx_o,
   output logic                     irq_o
);

   eth_host_pkg::ctrl_t              ctrl;
   eth_host_pkg::rx_status_t         rx_status;
   logic [eth_mii_pkg::LEN_W-1:0]    tx_len;
   logic                             send;
   logic                             rx_ack;
   logic                             tx_busy;

   // Transmit buffer, host writes and transmitter reads
   logic                             txbuf_wr;
   logic [eth_mii_pkg::BUFFER_W-1:0] txbuf_waddr;
   logic [7:0]                       txbuf_wdata;
   logic [eth_mii_pkg::BUFFER_W-1:0] txbuf_raddr;
   logic [7:0]                       txbuf_rdata;

   // Receive buffer, receiver writes and host reads
   logic                             rxbuf_wr;
   logic [eth_mii_pkg::BUFFER_W-1:0] rxbuf_waddr;
   logic [7:0]                       rxbuf_wdata;
   logic [eth_mii_pkg::BUFFER_W-1:0] rxbuf_raddr;
   logic [7:0]                       rxbuf_rdata;

   eth_host_regs regs (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .host_i       (host_i),
      .host_o       (host_o),
      .ctrl_o       (ctrl),
      .tx_len_o     (tx_len),
      .send_o       (send),
      .rx_ack_o     (rx_ack),
      .tx_busy_i    (tx_busy),
      .rx_status_i  (rx_status),
      .txbuf_wr_o   (txbuf_wr),
      .txbuf_addr_o (txbuf_waddr),
      .txbuf_data_o (txbuf_wdata),
      .rxbuf_raddr_o(rxbuf_raddr),
      .rxbuf_rdata_i(rxbuf_rdata)
   );

   eth_buffer_ram tx_buffer (
      .clk_i  (clk_i),
      .wr_i   (txbuf_wr),
      .waddr_i(txbuf_waddr),
      .wdata_i(txbuf_wdata),
      .raddr_i(txbuf_raddr),
      .rdata_o(txbuf_rdata)
   );

   eth_buffer_ram rx_buffer (
      .clk_i  (clk_i),
      .wr_i   (rxbuf_wr),
      .waddr_i(rxbuf_waddr),
      .wdata_i(rxbuf_wdata),
      .raddr_i(rxbuf_raddr),
      .rdata_o(rxbuf_rdata)
   );

   eth_tx tx (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .ctrl_i    (ctrl),
      .len_i     (tx_len),
      .send_i    (send),
      .busy_o    (tx_busy),
      .buf_addr_o(txbuf_raddr),
      .buf_data_i(txbuf_rdata),
      .mii_o     (mii_tx_o)
   );

   eth_rx rx (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .ctrl_i    (ctrl),
      .ack_i     (rx_ack),
      .mii_i     (mii_rx_i),
      .buf_wr_o  (rxbuf_wr),
      .buf_addr_o(rxbuf_waddr),
      .buf_data_o(rxbuf_wdata),
      .status_o  (rx_status)
   );

   assign irq_o = rx_status.done;  // Interrupt follows the receive done flag

endmodule

// File: logic/eth_rx.sv
`timescale 1ns/1ns

module eth_rx (
   input  logic                             clk_i,
   input  logic                             reset_i,
   input  eth_host_pkg::ctrl_t              ctrl_i,
   input  logic                             ack_i,
   input  eth_mii_pkg::mii_nibble_t         mii_i,
   output logic                             buf_wr_o,
   output logic [eth_mii_pkg::BUFFER_W-1:0] buf_addr_o,
   output logic [7:0]                       buf_data_o,
   output eth_host_pkg::rx_status_t         status_o
);

   eth_mii_pkg::rx_state_e           state_q;
   logic                             dv_q;       // rx_dv one cycle back
   logic                             hi_q;
   logic [3:0]                       lo_q;
   logic [eth_mii_pkg::LEN_W-1:0]    cnt_q;
   logic [eth_mii_pkg::LEN_W-1:0]    len_q;
   logic                             crc_err_q;
   logic                             wr_q;
   logic [eth_mii_pkg::BUFFER_W-1:0] waddr_q;
   logic [7:0]                       wdata_q;
   logic                             frame_start;
   logic                             sfd_seen;
   logic                             byte_done;
   logic [31:0]                      crc;

   // Only a fresh rx_dv edge opens a frame, so a frame already running is dropped whole
   assign frame_start = mii_i.en && !dv_q && ctrl_i.rx_en;
   assign sfd_seen    = (state_q == eth_mii_pkg::RX_PREAMBLE) && mii_i.en &&
                        (mii_i.data == eth_mii_pkg::SFD_NIBBLE);
   assign byte_done   = (state_q == eth_mii_pkg::RX_DATA) && mii_i.en && hi_q;

   eth_crc32 crc_unit (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .init_i  (sfd_seen),
      .en_i    ((state_q == eth_mii_pkg::RX_DATA) && mii_i.en),
      .nibble_i(mii_i.data),
      .crc_o   (crc)
   );

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q   <= eth_mii_pkg::RX_IDLE;
         dv_q      <= 1'b0;
         hi_q      <= 1'b0;
         cnt_q     <= '0;
         len_q     <= '0;
         crc_err_q <= 1'b0;
         wr_q      <= 1'b0;
      end else begin
         dv_q <= mii_i.en;
         wr_q <= byte_done && !cnt_q[eth_mii_pkg::LEN_W-1];  // Stop at a full buffer
         case (state_q)
            eth_mii_pkg::RX_IDLE: begin
               if (frame_start) state_q <= eth_mii_pkg::RX_PREAMBLE;
            end
            eth_mii_pkg::RX_PREAMBLE: begin
               if (!mii_i.en) begin
                  state_q <= eth_mii_pkg::RX_IDLE;  // Ended before the SFD
               end else if (sfd_seen) begin
                  state_q <= eth_mii_pkg::RX_DATA;
                  hi_q    <= 1'b0;
                  cnt_q   <= '0;
               end
            end
            eth_mii_pkg::RX_DATA: begin
               if (mii_i.en) begin
                  hi_q <= !hi_q;
                  if (byte_done && !cnt_q[eth_mii_pkg::LEN_W-1]) cnt_q <= cnt_q + 1'b1;
               end else if (cnt_q != '0) begin
                  state_q   <= eth_mii_pkg::RX_DONE;
                  len_q     <= cnt_q;
                  crc_err_q <= (crc != eth_mii_pkg::CRC_RESIDUE);
               end else begin
                  state_q <= eth_mii_pkg::RX_IDLE;  // No whole byte
               end
            end
            eth_mii_pkg::RX_DONE: begin
               if (ack_i) state_q <= eth_mii_pkg::RX_IDLE;
            end
            default: state_q <= eth_mii_pkg::RX_IDLE;
         endcase
      end
   end

   // Byte assembly, low nibble arrives first
   always_ff @(posedge clk_i) begin
      if (!hi_q) begin
         lo_q <= mii_i.data;
      end
      if (byte_done) begin
         waddr_q <= cnt_q[eth_mii_pkg::BUFFER_W-1:0];
         wdata_q <= {mii_i.data, lo_q};
      end
   end

   assign buf_wr_o   = wr_q;
   assign buf_addr_o = waddr_q;
   assign buf_data_o = wdata_q;

   assign status_o.done    = (state_q == eth_mii_pkg::RX_DONE);
   assign status_o.crc_err = crc_err_q;
   assign status_o.len     = len_q;

endmodule

// File: logic/eth_tx.sv
`timescale 1ns/1ns

module eth_tx (
   input  logic                             clk_i,
   input  logic                             reset_i,
   input  eth_host_pkg::ctrl_t              ctrl_i,
   input  logic [eth_mii_pkg::LEN_W-1:0]    len_i,
   input  logic                             send_i,
   output logic                             busy_o,
   output logic [eth_mii_pkg::BUFFER_W-1:0] buf_addr_o,
   input  logic [7:0]                       buf_data_i,
   output eth_mii_pkg::mii_nibble_t         mii_o
);

   eth_mii_pkg::tx_state_e        state_q;
   logic [3:0]                    nib_cnt_q;
   logic [eth_mii_pkg::LEN_W-1:0] byte_idx_q;
   logic [eth_mii_pkg::LEN_W-1:0] next_idx;
   logic [eth_mii_pkg::LEN_W-1:0] len_q;
   logic                          hi_q;      // High nibble of the current byte
   logic                          crc_en_q;
   logic                          start;
   logic [3:0]                    data_nibble;
   logic [31:0]                   crc;
   logic [31:0]                   fcs;

   assign start  = send_i && ctrl_i.tx_en && (state_q == eth_mii_pkg::TX_IDLE);
   assign busy_o = start || (state_q != eth_mii_pkg::TX_IDLE);

   // Next byte is addressed during the high nibble
   assign next_idx    = byte_idx_q + 1'b1;
   assign buf_addr_o  = hi_q ? next_idx[eth_mii_pkg::BUFFER_W-1:0]
                             : byte_idx_q[eth_mii_pkg::BUFFER_W-1:0];
   assign data_nibble = hi_q ? buf_data_i[7:4] : buf_data_i[3:0];
   assign fcs         = ~crc;

   eth_crc32 crc_unit (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .init_i  (start),
      .en_i    (state_q == eth_mii_pkg::TX_DATA),
      .nibble_i(data_nibble),
      .crc_o   (crc)
   );

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q    <= eth_mii_pkg::TX_IDLE;
         nib_cnt_q  <= '0;
         byte_idx_q <= '0;
         hi_q       <= 1'b0;
         crc_en_q   <= 1'b0;
      end else begin
         case (state_q)
            eth_mii_pkg::TX_IDLE: begin
               if (start) begin
                  state_q    <= eth_mii_pkg::TX_PREAMBLE;
                  nib_cnt_q  <= '0;
                  byte_idx_q <= '0;
                  hi_q       <= 1'b0;
                  crc_en_q   <= ctrl_i.crc_en;  // Held for the whole frame
               end
            end
            eth_mii_pkg::TX_PREAMBLE: begin
               nib_cnt_q <= nib_cnt_q + 1'b1;
               if (nib_cnt_q == 4'(eth_mii_pkg::PREAMBLE_NIBBLES - 1)) begin
                  state_q <= eth_mii_pkg::TX_SFD;
               end
            end
            eth_mii_pkg::TX_SFD: begin
               nib_cnt_q <= '0;
               if (len_q != '0) begin
                  state_q <= eth_mii_pkg::TX_DATA;
               end else begin
                  state_q <= crc_en_q ? eth_mii_pkg::TX_FCS : eth_mii_pkg::TX_IDLE;
               end
            end
            eth_mii_pkg::TX_DATA: begin
               hi_q <= !hi_q;
               if (hi_q) begin
                  byte_idx_q <= next_idx;
                  if (next_idx == len_q) begin  // Last byte done
                     state_q <= crc_en_q ? eth_mii_pkg::TX_FCS : eth_mii_pkg::TX_IDLE;
                  end
               end
            end
            eth_mii_pkg::TX_FCS: begin
               nib_cnt_q <= nib_cnt_q + 1'b1;
               if (nib_cnt_q == 4'(eth_mii_pkg::FCS_NIBBLES - 1)) begin
                  state_q <= eth_mii_pkg::TX_IDLE;
               end
            end
            default: state_q <= eth_mii_pkg::TX_IDLE;
         endcase
      end
   end

   // Frame length sampled with the send
   always_ff @(posedge clk_i) begin
      if (start) begin
         len_q <= len_i;
      end
   end

   always_comb begin
      mii_o.en = (state_q != eth_mii_pkg::TX_IDLE);
      case (state_q)
         eth_mii_pkg::TX_PREAMBLE: mii_o.data = eth_mii_pkg::PREAMBLE_NIBBLE;
         eth_mii_pkg::TX_SFD:      mii_o.data = eth_mii_pkg::SFD_NIBBLE;
         eth_mii_pkg::TX_DATA:     mii_o.data = data_nibble;
         eth_mii_pkg::TX_FCS:      mii_o.data = fcs[{nib_cnt_q[2:0], 2'b00} +: 4];
         default:                  mii_o.data = 4'h0;
      endcase
   end

endmodule

// File: logic/eth_host_regs.sv
`timescale 1ns/1ns

module eth_host_regs (
   input  logic                             clk_i,
   input  logic                             reset_i,
   input  eth_host_pkg::host_req_t          host_i,
   output eth_host_pkg::host_rsp_t          host_o,
   output eth_host_pkg::ctrl_t              ctrl_o,
   output logic [eth_mii_pkg::LEN_W-1:0]    tx_len_o,
   output logic                             send_o,
   output logic                             rx_ack_o,
   input  logic                             tx_busy_i,
   input  eth_host_pkg::rx_status_t         rx_status_i,
   output logic                             txbuf_wr_o,
   output logic [eth_mii_pkg::BUFFER_W-1:0] txbuf_addr_o,
   output logic [7:0]                       txbuf_data_o,
   output logic [eth_mii_pkg::BUFFER_W-1:0] rxbuf_raddr_o,
   input  logic [7:0]                       rxbuf_rdata_i
);

   logic                          buf_sel;
   eth_host_pkg::reg_addr_e       reg_addr;
   logic                          reg_wr;
   logic [7:0]                    reg_rdata;
   eth_host_pkg::ctrl_t           ctrl_q;
   logic [eth_mii_pkg::LEN_W-1:0] tx_len_q;
   logic                          send_q;
   logic                          ack_q;
   logic                          rvalid_q;
   logic                          rd_buf_q;
   logic [7:0]                    rd_reg_q;

   assign buf_sel  = host_i.addr[eth_host_pkg::BUF_SEL_BIT];
   assign reg_addr = eth_host_pkg::reg_addr_e'(host_i.addr[eth_host_pkg::ADDR_W-2:0]);
   assign reg_wr   = host_i.wr && !buf_sel;

   // Writes in the window go straight to the transmit buffer
   assign txbuf_wr_o   = host_i.wr && buf_sel;
   assign txbuf_addr_o = host_i.addr[eth_mii_pkg::BUFFER_W-1:0];
   assign txbuf_data_o = host_i.wdata;

   // Receive buffer is read every cycle, the result is used only after rd
   assign rxbuf_raddr_o = host_i.addr[eth_mii_pkg::BUFFER_W-1:0];

   always_comb begin
      case (reg_addr)
         eth_host_pkg::CTRL:   reg_rdata = {5'b0, ctrl_q};
         eth_host_pkg::TX_LEN: reg_rdata = 8'(tx_len_q);
         eth_host_pkg::STATUS: begin
            reg_rdata = {5'b0, rx_status_i.crc_err, rx_status_i.done, tx_busy_i};
         end
         eth_host_pkg::RX_ACK: reg_rdata = 8'(rx_status_i.len);  // Length, next to STATUS
         default:              reg_rdata = '0;  // SEND is a strobe
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         ctrl_q   <= '0;
         tx_len_q <= '0;
         send_q   <= 1'b0;
         ack_q    <= 1'b0;
         rvalid_q <= 1'b0;
      end else begin
         send_q   <= reg_wr && (reg_addr == eth_host_pkg::SEND);
         ack_q    <= reg_wr && (reg_addr == eth_host_pkg::RX_ACK);
         rvalid_q <= host_i.rd;
         if (reg_wr && (reg_addr == eth_host_pkg::CTRL)) begin
            ctrl_q <= eth_host_pkg::ctrl_t'(host_i.wdata[2:0]);
         end
         if (reg_wr && (reg_addr == eth_host_pkg::TX_LEN)) begin
            tx_len_q <= host_i.wdata[eth_mii_pkg::LEN_W-1:0];
         end
      end
   end

   // Read selection lines up with the registered buffer read
   always_ff @(posedge clk_i) begin
      if (host_i.rd) begin
         rd_buf_q <= buf_sel;
         rd_reg_q <= reg_rdata;
      end
   end

   assign host_o.rvalid = rvalid_q;
   assign host_o.rdata  = rd_buf_q ? rxbuf_rdata_i : rd_reg_q;

   assign ctrl_o   = ctrl_q;
   assign tx_len_o = tx_len_q;
   assign send_o   = send_q;
   assign rx_ack_o = ack_q;

endmodule

// File: logic/eth_buffer_ram.sv
`timescale 1ns/1ns

module eth_buffer_ram (
   input  logic                             clk_i,
   input  logic                             wr_i,
   input  logic [eth_mii_pkg::BUFFER_W-1:0] waddr_i,
   input  logic [7:0]                       wdata_i,
   input  logic [eth_mii_pkg::BUFFER_W-1:0] raddr_i,
   output logic [7:0]                       rdata_o
);

   logic [7:0] mem [2**eth_mii_pkg::BUFFER_W];

   always_ff @(posedge clk_i) begin
      if (wr_i) begin
         mem[waddr_i] <= wdata_i;
      end
      rdata_o <= mem[raddr_i];  // Data one cycle after the address
   end

endmodule

// File: logic/eth_crc32.sv
`timescale 1ns/1ns

module eth_crc32 (
   input  logic        clk_i,
   input  logic        reset_i,
   input  logic        init_i,
   input  logic        en_i,
   input  logic [3:0]  nibble_i,
   output logic [31:0] crc_o
);

   logic [31:0] crc_q;
   logic [31:0] crc_next;

   // Four serial steps, bit 0 of the nibble goes in first
   always_comb begin
      crc_next = crc_q;
      for (int i = 0; i < 4; i++) begin
         if (crc_next[0] ^ nibble_i[i]) begin
            crc_next = (crc_next >> 1) ^ eth_mii_pkg::CRC_POLY;
         end else begin
            crc_next = crc_next >> 1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i || init_i) begin
         crc_q <= eth_mii_pkg::CRC_INIT;
      end else if (en_i) begin
         crc_q <= crc_next;
      end
   end

   assign crc_o = crc_q;

endmodule

// File: logic/eth_host_pkg.sv
package eth_host_pkg;

   localparam int ADDR_W      = 9;
   localparam int BUF_SEL_BIT = ADDR_W - 1;  // Set for the buffer windows

   // Register map, RX_ACK also reads back the receive length
   typedef enum logic [ADDR_W-2:0] {
      CTRL,
      TX_LEN,
      SEND,
      STATUS,
      RX_ACK
   } reg_addr_e;

   typedef struct packed {
      logic              wr;
      logic              rd;
      logic [ADDR_W-1:0] addr;
      logic [7:0]        wdata;
   } host_req_t;

   typedef struct packed {
      logic       rvalid;
      logic [7:0] rdata;
   } host_rsp_t;

   // Member order puts tx_en at bit 0
   typedef struct packed {
      logic crc_en;
      logic rx_en;
      logic tx_en;
   } ctrl_t;

   typedef struct packed {
      logic                          done;
      logic                          crc_err;
      logic [eth_mii_pkg::LEN_W-1:0] len;
   } rx_status_t;

endpackage

// File: logic/eth_mii_pkg.sv
package eth_mii_pkg;

   // Frame buffer geometry
   localparam int BUFFER_W = 7;             // 128 bytes per buffer
   localparam int LEN_W    = BUFFER_W + 1;  // Byte count, room for a full buffer

   // Preamble and delimiter
   localparam int         PREAMBLE_NIBBLES = 15;
   localparam logic [3:0] PREAMBLE_NIBBLE  = 4'h5;
   localparam logic [3:0] SFD_NIBBLE       = 4'hD;

   // FCS nibbles after the data
   localparam int FCS_NIBBLES = 8;

   // Reflected CRC-32
   localparam logic [31:0] CRC_INIT    = 32'hFFFF_FFFF;
   localparam logic [31:0] CRC_POLY    = 32'hEDB8_8320;  // 04C11DB7 bit-reversed
   localparam logic [31:0] CRC_RESIDUE = 32'hDEBB_20E3;  // Register after data plus good FCS

   // One MII nibble, en is tx_en or rx_dv
   typedef struct packed {
      logic       en;
      logic [3:0] data;
   } mii_nibble_t;

   typedef enum logic [2:0] {
      TX_IDLE,
      TX_PREAMBLE,
      TX_SFD,
      TX_DATA,
      TX_FCS
   } tx_state_e;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_PREAMBLE,
      RX_DATA,
      RX_DONE
   } rx_state_e;

endpackage
